/* chipBusPkg.sv */
`default_nettype none

package chipBusPkg;

    // Default chip address width. Covers 1 MB of chip RAM plus the register window.
    localparam int DEF_ADDR_W = 21;

    // Default chip data width. The chip bus is a 16-bit bus.
    localparam int DEF_DATA_W = 16;

    // Default number of clocks a CPU slot holds the chip bus.
    localparam int DEF_SLOT_LEN = 4;

    // When this address bit is set the access goes to the chipset registers.
    // When it is clear the access goes to chip RAM.
    localparam int REG_BASE_BIT = 20;

    // AXI response code. Only OKAY is ever returned.
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // Opcode of one chip access, as issued by the host port.
    typedef enum logic [1:0] {
        accRamRead,
        accRamWrite,
        accRegRead,
        accRegWrite
    } accessKind;

    // States of the chip-bus cycle sequencer.
    typedef enum logic [2:0] {
        stIdle,
        stWaitDma,
        stAddr,
        stData,
        stLatch,
        stDone
    } cycleState;

endpackage

`default_nettype wire

/* chipReqIf.sv */
`default_nettype none

interface chipReqIf #(
    parameter int ADDR_W = chipBusPkg::DEF_ADDR_W,
    parameter int DATA_W = chipBusPkg::DEF_DATA_W
);
    // Carries a single chip access from the host port to the sequencer.
    // Only one request is ever in flight.
    import chipBusPkg::*;

    // The port raises req with kind, addr and wdata already settled.
    // All four stay unchanged until the sequencer answers with done.
    logic req;
    accessKind kind;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;

    // The sequencer pulses done for exactly one clock.
    // For reads, rdata holds the latched chip data in that same clock.
    logic done;
    logic [DATA_W-1:0] rdata;

    // Host port side.
    modport master (
        output req,
        output kind,
        output addr,
        output wdata,
        input  done,
        input  rdata
    );

    // Sequencer side.
    modport slave (
        input  req,
        input  kind,
        input  addr,
        input  wdata,
        output done,
        output rdata
    );

endinterface

`default_nettype wire

/* axiLiteChipPort.sv */
`default_nettype none

module axiLiteChipPort #(
    parameter int ADDR_W = chipBusPkg::DEF_ADDR_W,
    parameter int DATA_W = chipBusPkg::DEF_DATA_W
) (
    input  wire logic              clk28,
    input  wire logic              rst,
    input  wire logic [ADDR_W-1:0] awaddr,
    input  wire logic              awvalid,
    output logic                   awready,
    input  wire logic [DATA_W-1:0] wdata,
    input  wire logic              wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  wire logic              bready,
    input  wire logic [ADDR_W-1:0] araddr,
    input  wire logic              arvalid,
    output logic                   arready,
    output logic [DATA_W-1:0]      rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  wire logic              rready,
    chipReqIf.master               chip
);
    import chipBusPkg::*;

    // The port walks through these states once per host transaction.
    typedef enum logic [1:0] {
        psIdle,
        psAccept,
        psBusy,
        psResp
    } portState;

    portState state;

    // Remembers whether the transaction in flight is a read.
    logic isRead;

    // No error path exists, so both responses are always OKAY.
    assign bresp = RESP_OKAY;
    assign rresp = RESP_OKAY;

    ////////////////////////////////////////////////////////////
    // Handshake control
    ////////////////////////////////////////////////////////////

    // Ready is raised for one clock only after the valids are seen in idle.
    // AXI keeps valid high until ready, so the transfer lands in psAccept.
    // A read wins over a write that shows up in the same idle clock.
    always_ff @(posedge clk28) begin
        if (rst) begin
            state    <= psIdle;
            isRead   <= 1'b0;
            awready  <= 1'b0;
            wready   <= 1'b0;
            arready  <= 1'b0;
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            chip.req <= 1'b0;
        end else begin
            case (state)
                psIdle: begin
                    if (arvalid) begin
                        arready <= 1'b1;
                        isRead  <= 1'b1;
                        state   <= psAccept;
                    end else if (awvalid && wvalid) begin
                        awready <= 1'b1;
                        wready  <= 1'b1;
                        isRead  <= 1'b0;
                        state   <= psAccept;
                    end
                end
                psAccept: begin
                    // The transfer completes on this edge.
                    arready  <= 1'b0;
                    awready  <= 1'b0;
                    wready   <= 1'b0;
                    chip.req <= 1'b1;
                    state    <= psBusy;
                end
                psBusy: begin
                    if (chip.done) begin
                        chip.req <= 1'b0;
                        bvalid   <= !isRead;
                        rvalid   <= isRead;
                        state    <= psResp;
                    end
                end
                psResp: begin
                    // Nothing new is taken while the host holds off the response.
                    if ((bvalid && bready) || (rvalid && rready)) begin
                        bvalid <= 1'b0;
                        rvalid <= 1'b0;
                        state  <= psIdle;
                    end
                end
                default: state <= psIdle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Request and response payload
    ////////////////////////////////////////////////////////////

    // The address bit at REG_BASE_BIT picks register space over chip RAM.
    // Reads drive wdata to zero so the request never carries unknown bits.
    always_ff @(posedge clk28) begin
        if (state == psAccept) begin
            if (isRead) begin
                chip.addr  <= araddr;
                chip.wdata <= '0;
                chip.kind  <= araddr[REG_BASE_BIT] ? accRegRead : accRamRead;
            end else begin
                chip.addr  <= awaddr;
                chip.wdata <= wdata;
                chip.kind  <= awaddr[REG_BASE_BIT] ? accRegWrite : accRamWrite;
            end
        end
        if (state == psBusy && chip.done) begin
            rdata <= chip.rdata;
        end
    end

    // A single transaction is in flight, so only one response can be pending.
    respExclusive: assert property (@(posedge clk28) disable iff (rst)
        !(bvalid && rvalid))
        else $error("bvalid and rvalid are high together");

endmodule

`default_nettype wire

/* chipCycleSequencer.sv */
`default_nettype none

module chipCycleSequencer #(
    parameter int ADDR_W   = chipBusPkg::DEF_ADDR_W,
    parameter int DATA_W   = chipBusPkg::DEF_DATA_W,
    parameter int SLOT_LEN = chipBusPkg::DEF_SLOT_LEN
) (
    input  wire logic              clk28,
    input  wire logic              rst,
    chipReqIf.slave                chip,
    input  wire logic              casUn,
    input  wire logic              casLn,
    input  wire logic [DATA_W-1:0] latchedData,
    output logic                   regCycle,
    output logic                   regCpuCycle,
    output logic                   regWriteCycle,
    output logic                   cpuCycle,
    output logic                   writeCycle,
    output logic                   latchRam,
    output logic                   latchReg,
    output logic [ADDR_W-1:0]      chipAddr,
    output logic [DATA_W-1:0]      chipDataOut,
    output logic                   rnW
);
    import chipBusPkg::*;

    localparam int CNT_W = $clog2(SLOT_LEN + 1);

    cycleState state;
    accessKind curKind;
    logic [CNT_W-1:0] slotCnt;

    logic slotStart;
    logic inSlot;
    logic isReg;
    logic isWrite;

    ////////////////////////////////////////////////////////////
    // Slot timing
    ////////////////////////////////////////////////////////////

    // The DMA agent owns the bus while either CAS strobe is low.
    // A CPU slot may begin only on a clock where both strobes are idle.
    assign slotStart = (state == stWaitDma) && casUn && casLn;

    // The slot is stAddr, then SLOT_LEN-2 clocks of stData, then stLatch.
    // CAS is not looked at again once the slot has started.
    always_ff @(posedge clk28) begin
        if (rst) begin
            state   <= stIdle;
            slotCnt <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (chip.req) begin
                        state <= stWaitDma;
                    end
                end
                stWaitDma: begin
                    if (slotStart) begin
                        slotCnt <= CNT_W'(SLOT_LEN - 1);
                        state   <= stAddr;
                    end
                end
                stAddr: begin
                    slotCnt <= slotCnt - 1'b1;
                    state   <= stData;
                end
                stData: begin
                    slotCnt <= slotCnt - 1'b1;
                    if (slotCnt == CNT_W'(1)) begin
                        state <= stLatch;
                    end
                end
                stLatch: state <= stDone;
                stDone:  state <= stIdle;
                default: state <= stIdle;
            endcase
        end
    end

    // Address, write data and opcode are frozen for the whole slot.
    always_ff @(posedge clk28) begin
        if (slotStart) begin
            curKind     <= chip.kind;
            chipAddr    <= chip.addr;
            chipDataOut <= chip.wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Cycle qualifiers
    ////////////////////////////////////////////////////////////

    assign inSlot  = (state == stAddr) || (state == stData) || (state == stLatch);
    assign isReg   = (curKind == accRegRead) || (curKind == accRegWrite);
    assign isWrite = (curKind == accRamWrite) || (curKind == accRegWrite);

    // A register cycle owns the chipset side for the full slot.
    // The CPU buffers join after the address clock so the chipset sees a settled address.
    assign regCycle      = inSlot && isReg;
    assign regCpuCycle   = ((state == stData) || (state == stLatch)) && isReg;
    assign regWriteCycle = regCycle && isWrite;
    assign cpuCycle      = inSlot && !isReg;
    assign writeCycle    = inSlot && isWrite;
    assign rnW           = !writeCycle;

    // Read data is strobed into the buffer latch in the last slot clock.
    assign latchRam = (state == stLatch) && !isReg && !isWrite;
    assign latchReg = (state == stLatch) && isReg && !isWrite;

    // The latch has captured the data by the time done is up.
    assign chip.done  = (state == stDone);
    assign chip.rdata = latchedData;

    // The host port must hold its request until the slot completes.
    reqStable: assert property (@(posedge clk28) disable iff (rst)
        (chip.req && !chip.done) |=> (chip.req && $stable(chip.kind)
            && $stable(chip.addr) && $stable(chip.wdata)))
        else $error("chip request changed before done");

    // A slot is opened only after a clock with both CAS strobes idle.
    noSlotDuringDma: assert property (@(posedge clk28) disable iff (rst)
        $rose(regCycle || cpuCycle) |-> $past(casUn && casLn))
        else $error("CPU slot started during a DMA cycle");

    // A slot targets RAM or registers, never both.
    qualExclusive: assert property (@(posedge clk28) disable iff (rst)
        !(regCycle && cpuCycle))
        else $error("regCycle and cpuCycle are high together");

endmodule

`default_nettype wire

/* chipBuffers.sv */
`default_nettype none

module chipBuffers #(
    parameter int DATA_W = chipBusPkg::DEF_DATA_W
) (
    input  wire logic              clk28,
    input  wire logic              rst,
    input  wire logic              regCycle,
    input  wire logic              regCpuCycle,
    input  wire logic              regWriteCycle,
    input  wire logic              cpuCycle,
    input  wire logic              writeCycle,
    input  wire logic              latchRam,
    input  wire logic              latchReg,
    input  wire logic              casUn,
    input  wire logic              casLn,
    input  wire logic [DATA_W-1:0] chipDataIn,
    output logic                   vbenN,
    output logic                   drdenN,
    output logic                   drdDir,
    output logic                   dmaLatchEn,
    output logic                   latchClk,
    output logic [DATA_W-1:0]      latchedData
);

    ////////////////////////////////////////////////////////////
    // Transceiver enables and direction
    ////////////////////////////////////////////////////////////

    // Either CAS strobe low means the DMA agent is running a cycle.
    logic dmaCycle;
    assign dmaCycle = !casUn || !casLn;

    // The CPU-side buffer opens only while the CPU has a live slot.
    assign vbenN = !(regCpuCycle || cpuCycle);

    // The chipset-side transceiver serves DMA traffic and every register cycle.
    assign drdenN = !(dmaCycle || regCycle);

    // Register cycles drive toward the chipset only when writing.
    // Outside register cycles the transceiver faces the latch unless the CPU writes RAM.
    assign drdDir = regCycle ? regWriteCycle : !writeCycle;

    // The latch enable follows the same rule but goes to its own pin.
    // Register write data is held in the latch until the slot ends.
    assign dmaLatchEn = regCycle ? regWriteCycle : !writeCycle;

    ////////////////////////////////////////////////////////////
    // Read data latch
    ////////////////////////////////////////////////////////////

    // One strobe per read source, merged onto the shared latch clock.
    assign latchClk = latchRam || latchReg;

    // Captures the chip bus in the clock where the strobe is high.
    always_ff @(posedge clk28) begin
        if (latchClk) begin
            latchedData <= chipDataIn;
        end
    end

    // The latch may only fire while the CPU buffers are connected.
    latchInSlot: assert property (@(posedge clk28) disable iff (rst)
        $rose(latchClk) |-> !vbenN)
        else $error("latchClk rose with the CPU buffers disabled");

endmodule

`default_nettype wire

/* chipBusTop.sv */
`default_nettype none

module chipBusTop #(
    parameter int ADDR_W   = chipBusPkg::DEF_ADDR_W,
    parameter int DATA_W   = chipBusPkg::DEF_DATA_W,
    parameter int SLOT_LEN = chipBusPkg::DEF_SLOT_LEN
) (
    input  wire logic              clk28,
    input  wire logic              rst,
    input  wire logic [ADDR_W-1:0] awaddr,
    input  wire logic              awvalid,
    output logic                   awready,
    input  wire logic [DATA_W-1:0] wdata,
    input  wire logic              wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  wire logic              bready,
    input  wire logic [ADDR_W-1:0] araddr,
    input  wire logic              arvalid,
    output logic                   arready,
    output logic [DATA_W-1:0]      rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  wire logic              rready,
    output logic [ADDR_W-1:0]      chipAddr,
    output logic [DATA_W-1:0]      chipDataOut,
    input  wire logic [DATA_W-1:0] chipDataIn,
    output logic                   rnW,
    input  wire logic              casUn,
    input  wire logic              casLn,
    output logic                   vbenN,
    output logic                   drdenN,
    output logic                   drdDir,
    output logic                   dmaLatchEn,
    output logic                   latchClk
);

    // Cycle qualifiers from the sequencer to the buffer block.
    logic regCycle;
    logic regCpuCycle;
    logic regWriteCycle;
    logic cpuCycle;
    logic writeCycle;
    logic latchRam;
    logic latchReg;

    // Latched chip read data on its way back to the host.
    logic [DATA_W-1:0] latchedData;

    chipReqIf #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) chipReq ();

    axiLiteChipPort #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) hostPort (
        .chip(chipReq.master),
        .*
    );

    chipCycleSequencer #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SLOT_LEN(SLOT_LEN)) sequencer (
        .chip(chipReq.slave),
        .*
    );

    chipBuffers #(.DATA_W(DATA_W)) buffers (.*);

endmodule

`default_nettype wire

/* tbChipChecks.sv */
`default_nettype none

module tbChipChecks #(
    parameter int ADDR_W = 21,
    parameter int DATA_W = 16
) (
    input  wire logic              clk28,
    input  wire logic              rst,
    input  wire logic              awvalid,
    input  wire logic              awready,
    input  wire logic              wready,
    input  wire logic [1:0]        bresp,
    input  wire logic              bvalid,
    input  wire logic              bready,
    input  wire logic              arvalid,
    input  wire logic              arready,
    input  wire logic [DATA_W-1:0] rdata,
    input  wire logic [1:0]        rresp,
    input  wire logic              rvalid,
    input  wire logic              rready,
    input  wire logic [ADDR_W-1:0] chipAddr,
    input  wire logic [DATA_W-1:0] chipDataOut,
    input  wire logic              rnW,
    input  wire logic              casUn,
    input  wire logic              casLn,
    input  wire logic              vbenN,
    input  wire logic              drdenN,
    input  wire logic              drdDir,
    input  wire logic              dmaLatchEn,
    input  wire logic              latchClk,
    input  wire logic [DATA_W-1:0] expWdata,
    input  wire logic [DATA_W-1:0] expRdata,
    output int                     errCount
);
    timeunit 1ns;
    timeprecision 1ps;
    import chipBusPkg::*;

    localparam logic [1:0] OKAY = 2'b00;

    int failCount = 0;
    int latchCount;
    logic cpuOwn;

    assign errCount = failCount;

    // The bus model never pulls CAS low during a CPU slot.
    // So a low drdenN with both strobes high can only be a register slot.
    assign cpuOwn = !vbenN || (!drdenN && casUn && casLn);

    task automatic flagError(input string msg);
        failCount++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    // Latch pulses seen since the last accepted host transaction.
    always_ff @(posedge clk28) begin
        if (rst || (awvalid && awready) || (arvalid && arready)) begin
            latchCount <= 0;
        end else if (latchClk) begin
            latchCount <= latchCount + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Reset and DMA exclusion
    ////////////////////////////////////////////////////////////

    resetQuiet: assert property (@(posedge clk28)
        rst |=> (!awready && !wready && !arready && !bvalid && !rvalid
            && vbenN && drdenN && !latchClk))
        else flagError("outputs not idle during or just after reset");

    dmaOpensDrd: assert property (@(posedge clk28) disable iff (rst)
        !(casUn && casLn) |-> !drdenN)
        else flagError("drdenN inactive while a CAS strobe is low");

    // The edge that opened the slot must have seen both strobes idle.
    slotAfterIdle: assert property (@(posedge clk28) disable iff (rst)
        $rose(cpuOwn) |-> $past(casUn && casLn))
        else flagError("CPU slot began while DMA held a CAS strobe");

    ////////////////////////////////////////////////////////////
    // Write direction and data
    ////////////////////////////////////////////////////////////

    regWriteDrive: assert property (@(posedge clk28) disable iff (rst)
        (!vbenN && !rnW && chipAddr[REG_BASE_BIT])
            |-> (drdDir && dmaLatchEn && chipDataOut == expWdata))
        else flagError("register write has wrong direction or data");

    ramWriteDrive: assert property (@(posedge clk28) disable iff (rst)
        (!vbenN && !rnW && !chipAddr[REG_BASE_BIT])
            |-> (!drdDir && !dmaLatchEn && chipDataOut == expWdata))
        else flagError("RAM write has wrong direction or data");

    okayResp: assert property (@(posedge clk28) disable iff (rst)
        (bvalid || rvalid) |-> (bresp == OKAY && rresp == OKAY))
        else flagError("response code is not OKAY");

    ////////////////////////////////////////////////////////////
    // Reads and the data latch
    ////////////////////////////////////////////////////////////

    readData: assert property (@(posedge clk28) disable iff (rst)
        rvalid |-> rdata == expRdata)
        else flagError("read data differs from the reference memory");

    // A single clock wide strobe, only inside a read slot.
    latchOnRead: assert property (@(posedge clk28) disable iff (rst)
        latchClk |-> rnW ##1 !latchClk)
        else flagError("latchClk pulsed during a write or ran too long");

    oneLatchPerRead: assert property (@(posedge clk28) disable iff (rst)
        $rose(rvalid) |-> latchCount == 1)
        else flagError("read finished without exactly one latch pulse");

    noLatchOnWrite: assert property (@(posedge clk28) disable iff (rst)
        $rose(bvalid) |-> latchCount == 0)
        else flagError("write produced a latch pulse");

    ////////////////////////////////////////////////////////////
    // Back-pressure
    ////////////////////////////////////////////////////////////

    writeRespHold: assert property (@(posedge clk28) disable iff (rst)
        (bvalid && !bready) |=> bvalid)
        else flagError("bvalid dropped before bready");

    readRespHold: assert property (@(posedge clk28) disable iff (rst)
        (rvalid && !rready) |=> (rvalid && $stable(rdata)))
        else flagError("rvalid dropped or rdata moved before rready");

    quietWhileResp: assert property (@(posedge clk28) disable iff (rst)
        (bvalid || rvalid) |-> (!cpuOwn && !awready && !wready && !arready))
        else flagError("new work started while a response was pending");

endmodule

`default_nettype wire

/* tbChipBus.sv */
`default_nettype none

module tbChipBus;
    timeunit 1ns;
    timeprecision 1ps;
    import chipBusPkg::*;

    localparam int ADDR_W    = 21;
    localparam int DATA_W    = 16;
    localparam int SLOT_LEN  = 4;
    localparam int NUM_ACC   = 40;
    localparam int MAX_BURST = 8;
    localparam int MAX_STALL = 4;
    localparam int SEED      = 32'h75e82eb3;

    // Worst case per access is a full CAS burst, the slot and the handshakes.
    localparam int WATCHDOG_NS = (NUM_ACC * (SLOT_LEN + MAX_BURST + 20) + 20) * 10;

    logic clk28;
    logic rst;
    logic [ADDR_W-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [DATA_W-1:0] wdata;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [ADDR_W-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [DATA_W-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic [ADDR_W-1:0] chipAddr;
    logic [DATA_W-1:0] chipDataOut;
    logic [DATA_W-1:0] chipDataIn = '0;
    logic rnW;
    logic casUn = 1'b1;
    logic casLn = 1'b1;
    logic vbenN;
    logic drdenN;
    logic drdDir;
    logic dmaLatchEn;
    logic latchClk;

    // Values the checker compares against, taken from the stimulus.
    logic [DATA_W-1:0] expWdata = '0;
    logic [DATA_W-1:0] expRdata = '0;
    int errCount;
    int nWrites = 0;
    int nReads = 0;
    int burstLeft = 0;

    // Chip-side contents as seen by the bus model, and the host-side prediction.
    logic [DATA_W-1:0] chipMem [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] refMem [logic [ADDR_W-1:0]];

    chipBusTop #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .SLOT_LEN(SLOT_LEN)) dut (.*);

    tbChipChecks #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) checks (.*);

    initial begin
        clk28 = 1'b0;
        forever #5 clk28 = ~clk28;
    end

    // Unwritten locations read back a value that mixes every address bit.
    function automatic logic [DATA_W-1:0] fillPattern(input logic [ADDR_W-1:0] a);
        return a[15:0] ^ {a[20:16], a[10:0]} ^ 16'hC35A;
    endfunction

    task automatic stepClk();
        @(posedge clk28);
        #1;
    endtask

    ////////////////////////////////////////////////////////////
    // Chip-bus model
    ////////////////////////////////////////////////////////////

    // RAM and registers. Writes land while rnW is low, reads follow chipAddr.
    always @(posedge clk28) begin
        #1;
        if (!$isunknown(chipAddr)) begin
            if (rnW === 1'b0) begin
                chipMem[chipAddr] = chipDataOut;
            end
            chipDataIn = chipMem.exists(chipAddr) ? chipMem[chipAddr] : fillPattern(chipAddr);
        end
    end

    // DMA agent. It starts random CAS bursts but leaves a running CPU slot alone.
    always @(posedge clk28) begin
        logic inReset;
        logic cpuOwn;
        int pick;
        inReset = rst;
        #1;
        cpuOwn = !vbenN || (!drdenN && casUn && casLn);
        if (inReset) begin
            casUn = 1'b1;
            casLn = 1'b1;
            burstLeft = 0;
        end else if (burstLeft > 0) begin
            burstLeft--;
            if (burstLeft == 0) begin
                casUn = 1'b1;
                casLn = 1'b1;
            end
        end else if (!cpuOwn && ($urandom % 4 == 0)) begin
            // Both strobes, or just one byte lane.
            pick = $urandom % 3;
            burstLeft = 1 + $urandom % MAX_BURST;
            casUn = (pick == 1);
            casLn = (pick == 2);
        end
    end

    ////////////////////////////////////////////////////////////
    // Host side
    ////////////////////////////////////////////////////////////

    // Raises the request channels of one access without waiting for ready.
    task automatic presentAccess(input logic isWrite, input logic [ADDR_W-1:0] addr,
            input logic [DATA_W-1:0] data);
        if (isWrite) begin
            expWdata = data;
            refMem[addr] = data;
            awaddr = addr;
            wdata = data;
            awvalid = 1'b1;
            wvalid = 1'b1;
        end else begin
            araddr = addr;
            arvalid = 1'b1;
        end
    endtask

    // Waits for the handshake, drops the valids and waits for the response.
    task automatic completeRequest(input logic isWrite);
        if (isWrite) begin
            while (!awready) stepClk();
        end else begin
            while (!arready) stepClk();
        end
        stepClk();
        awvalid = 1'b0;
        wvalid = 1'b0;
        arvalid = 1'b0;
        if (isWrite) begin
            while (!bvalid) stepClk();
        end else begin
            while (!rvalid) stepClk();
        end
    endtask

    // Holds off the pending response for a while to exercise back-pressure.
    task automatic takeResponse(input logic isWrite);
        int stall;
        stall = $urandom % MAX_STALL;
        repeat (stall) stepClk();
        if (isWrite) begin
            bready = 1'b1;
        end else begin
            rready = 1'b1;
        end
        stepClk();
        bready = 1'b0;
        rready = 1'b0;
        if (isWrite) begin
            nWrites++;
        end else begin
            nReads++;
        end
    endtask

    initial begin
        int seedVal;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic isWrite;
        logic lastWrite;
        seedVal = $urandom(SEED);
        lastWrite = 1'b0;
        rst = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        repeat (10) @(posedge clk28);
        #1;
        rst = 1'b0;
        // A small address pool in each space makes reads hit earlier writes.
        for (int i = 0; i < NUM_ACC; i++) begin
            addr = '0;
            addr[REG_BASE_BIT] = 1'($urandom % 2);
            addr[3:1] = 3'($urandom % 8);
            data = DATA_W'($urandom);
            isWrite = ($urandom % 2 == 0);
            repeat ($urandom % 3) stepClk();
            // The next request is already up while the previous response is held.
            presentAccess(isWrite, addr, data);
            if (i > 0) begin
                takeResponse(lastWrite);
            end
            if (!isWrite) begin
                expRdata = refMem.exists(addr) ? refMem[addr] : fillPattern(addr);
            end
            completeRequest(isWrite);
            lastWrite = isWrite;
        end
        takeResponse(lastWrite);
        repeat (5) stepClk();
        $display("Summary: %0d writes, %0d reads, %0d assertion failures",
            nWrites, nReads, errCount);
        if (errCount == 0 && nWrites + nReads == NUM_ACC) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Ends a run that stopped making progress.
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0t with %0d of %0d accesses finished",
            $time, nWrites + nReads, NUM_ACC);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
chipBusPkg.sv
chipReqIf.sv
axiLiteChipPort.sv
chipCycleSequencer.sv
chipBuffers.sv
chipBusTop.sv
tbChipChecks.sv
tbChipBus.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbChipBus
FILELIST  ?= src.f
BUILDDIR  ?= obj_dir
LOG       ?= sim.log
FAILMSG   ?= *** TEST FAILED ***
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILDDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILDDIR) -f $(FILELIST)

sim: $(BUILDDIR)/V$(TOP)
	@./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -qF '$(FAILMSG)' $(LOG); then \
	    echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILDDIR) $(LOG)
